// ==== rtl/bubble_pkg.sv ====
package bubble_pkg;

    // buffer geometry
    localparam int buf_addr_w  = 13;          // 8192 entries per channel
    localparam int host_addr_w = 14;          // bit 0 channel, 13:1 entry

    // access type as seen on the emulator side
    typedef enum logic [2:0] {
        acc_idle = 3'b000,                    // empty propagation line, addr all ones
        acc_boot = 3'b110,                    // boot loop, addr = cycle number
        acc_user = 3'b111                     // user page, region from 7168
    } acc_type_e;

    // host command opcodes
    typedef enum logic [1:0] {
        op_write_bit  = 2'd0,                 // data bit into buffer at addr
        op_set_access = 2'd1,                 // access type from addr[2:0]
        op_set_length = 2'd2,                 // read length from addr[12:0]
        op_start      = 2'd3                  // kick off a read
    } host_op_e;

    // host command, held stable by the host while req is high
    typedef struct packed {
        host_op_e               op;
        logic [host_addr_w-1:0] addr;
        logic                   data;
    } host_cmd_t;

    // bubble detector lines, already inverted
    typedef struct packed {
        logic valid;
        logic dout0;
        logic dout1;
    } bubble_out_t;

    // read request from sequencer to buffers
    typedef struct packed {
        logic                  valid;
        logic [buf_addr_w-1:0] addr;
    } rd_req_t;

endpackage

// ==== rtl/bubble_host_port.sv ====
`timescale 1ns/1ps

module bubble_host_port
(
    input  logic                  BOUTTICKS,
    input  logic                  reset,
    input  logic                  req,          // four-phase request from host
    input  bubble_pkg::host_cmd_t cmd,          // stable while req high
    output logic                  ack,
    output logic                  cmd_stb,      // one cycle per handshake
    output bubble_pkg::host_cmd_t cmd_q         // command seen by the core
);

    import bubble_pkg::*;

    typedef enum logic {
        wait_req,                               // idle, ack low
        wait_release                            // command taken, ack high
    } port_state_e;

    port_state_e state;

    // strobe on the first edge req is seen high
    // executes at that same edge, ack follows one cycle later
    assign cmd_stb = (state == wait_req) && req;

    // host holds cmd until ack, core only looks at it under cmd_stb
    assign cmd_q = cmd;

    // ack comes straight from the state register
    assign ack = (state == wait_release);

    always_ff @(posedge BOUTTICKS)
    begin
        if (reset)
        begin
            state <= wait_req;
        end
        else
        begin
            case (state)
                wait_req:
                begin
                    if (req)
                    begin
                        state <= wait_release;      // raise ack
                    end
                end
                wait_release:
                begin
                    if (!req)
                    begin
                        state <= wait_req;          // host let go, drop ack
                    end
                end
                default:
                begin
                    state <= wait_req;
                end
            endcase
        end
    end

endmodule

// ==== rtl/bubble_cfg_regs.sv ====
`timescale 1ns/1ps

module bubble_cfg_regs
(
    input  logic                                BOUTTICKS,
    input  logic                                reset,
    input  logic                                cmd_stb,
    input  bubble_pkg::host_cmd_t               cmd,
    input  logic                                done,       // from sequencer
    output bubble_pkg::acc_type_e               acc_type,
    output logic [bubble_pkg::buf_addr_w-1:0]   rd_len,
    output logic                                start,      // one-cycle kick
    output logic                                busy
);

    import bubble_pkg::*;

    always_ff @(posedge BOUTTICKS)
    begin
        if (reset)
        begin
            acc_type <= acc_idle;
            rd_len   <= '0;
            start    <= 1'b0;
            busy     <= 1'b0;
        end
        else
        begin
            start <= 1'b0;                          // pulse by default

            if (done)
            begin
                busy <= 1'b0;                       // falls with last rd.valid
            end

            if (cmd_stb)
            begin
                case (cmd.op)
                    op_set_access:
                    begin
                        // unknown codes fall back to the empty line
                        case (cmd.addr[2:0])
                            acc_boot: acc_type <= acc_boot;
                            acc_user: acc_type <= acc_user;
                            default:  acc_type <= acc_idle;
                        endcase
                    end
                    op_set_length:
                    begin
                        rd_len <= cmd.addr[buf_addr_w-1:0];  // allowed mid-read
                    end
                    op_start:
                    begin
                        // restart during a read is dropped here and only here
                        if (!busy)
                        begin
                            busy  <= 1'b1;
                            start <= 1'b1;
                        end
                    end
                    default:
                    begin
                        // write bits go to the buffers
                    end
                endcase
            end
        end
    end

endmodule

// ==== rtl/bubble_read_sequencer.sv ====
`timescale 1ns/1ps

module bubble_read_sequencer
#(
    parameter int page_bits = 10                // cycle bits kept in user page mode
)
(
    input  logic                                BOUTTICKS,
    input  logic                                reset,
    input  logic                                start,
    input  bubble_pkg::acc_type_e               acc_type,
    input  logic [bubble_pkg::buf_addr_w-1:0]   rd_len,
    output bubble_pkg::rd_req_t                 rd,
    output logic                                done
);

    import bubble_pkg::*;

    logic                  active_q;            // read burst in progress
    logic [buf_addr_w-1:0] cycle_q;             // bubble output cycle number
    logic [buf_addr_w-1:0] len_q;               // latched at start
    acc_type_e             acc_q;               // latched at start
    logic                  last_cycle;

    assign last_cycle = active_q && (cycle_q == len_q - 1'b1);

    // zero length finishes on the start cycle with no reads
    assign done = last_cycle || (start && (rd_len == '0));

    always_ff @(posedge BOUTTICKS)
    begin
        if (reset)
        begin
            active_q <= 1'b0;
            cycle_q  <= '0;
        end
        else if (start)
        begin
            active_q <= (rd_len != '0);
            cycle_q  <= '0;
        end
        else if (active_q)
        begin
            if (last_cycle)
            begin
                active_q <= 1'b0;               // burst over
            end
            else
            begin
                cycle_q <= cycle_q + 1'b1;
            end
        end
    end

    // setup latched once per read, later register writes wait for the next start
    always_ff @(posedge BOUTTICKS)
    begin
        if (start)
        begin
            acc_q <= acc_type;
            len_q <= rd_len;
        end
    end

    // access type to buffer address
    always_comb
    begin
        rd.valid = active_q;
        case (acc_q)
            acc_boot:
            begin
                rd.addr = cycle_q;              // straight replay
            end
            acc_user:
            begin
                // page region 7168 up
                rd.addr = {{(buf_addr_w-page_bits){1'b1}}, cycle_q[page_bits-1:0]};
            end
            default:
            begin
                rd.addr = '1;                   // empty propagation line
            end
        endcase
    end

endmodule

// ==== rtl/bubble_outbuffer.sv ====
`timescale 1ns/1ps

module bubble_outbuffer
#(
    parameter int depth = 8192                  // entries per channel
)
(
    input  logic                    BOUTTICKS,
    input  logic                    cmd_stb,
    input  bubble_pkg::host_cmd_t   cmd,
    input  bubble_pkg::rd_req_t     rd,
    input  logic                    reset,
    output bubble_pkg::bubble_out_t bout
);

    import bubble_pkg::*;

    logic                  chan_mem [2][depth]; // [0] feeds dout0, [1] dout1
    logic                  wr_en;
    logic                  wr_ch;
    logic [buf_addr_w-1:0] wr_addr;
    logic                  rd0_q;
    logic                  rd1_q;
    logic                  valid_q;

    // host address, bit 0 is the channel
    assign wr_en   = cmd_stb && (cmd.op == op_write_bit);
    assign wr_ch   = cmd.addr[0];
    assign wr_addr = cmd.addr[host_addr_w-1:1];

    always_ff @(posedge BOUTTICKS)
    begin
        if (wr_en)
        begin
            chan_mem[wr_ch][wr_addr] <= cmd.data;
        end
    end

    // tick-registered read, one cycle latency
    always_ff @(posedge BOUTTICKS)
    begin
        if (rd.valid)
        begin
            rd0_q <= chan_mem[0][rd.addr];
            rd1_q <= chan_mem[1][rd.addr];
        end
    end

    always_ff @(posedge BOUTTICKS)
    begin
        if (reset)
        begin
            valid_q <= 1'b0;
        end
        else
        begin
            valid_q <= rd.valid;
        end
    end

    // detector lines are active low
    assign bout.valid = valid_q;
    assign bout.dout0 = ~rd0_q;
    assign bout.dout1 = ~rd1_q;

endmodule

// ==== rtl/bubble_interface_top.sv ====
`timescale 1ns/1ps

module bubble_interface_top
#(
    parameter int buf_depth = 1 << bubble_pkg::buf_addr_w,  // per channel
    parameter int page_bits = 10                            // user page offset bits
)
(
    input  logic                    BOUTTICKS,  // one edge per bubble output cycle
    input  logic                    reset,
    input  logic                    req,
    input  bubble_pkg::host_cmd_t   cmd,
    output logic                    ack,
    output bubble_pkg::bubble_out_t bout,
    output logic                    busy
);

    import bubble_pkg::*;

    logic                  cmd_stb;
    host_cmd_t             cmd_q;
    acc_type_e             acc_type;
    logic [buf_addr_w-1:0] rd_len;
    logic                  start;
    logic                  done;
    rd_req_t               rd;

    // host handshake
    bubble_host_port host_port_i
    (
        .BOUTTICKS (BOUTTICKS),
        .reset     (reset),
        .req       (req),
        .cmd       (cmd),
        .ack       (ack),
        .cmd_stb   (cmd_stb),
        .cmd_q     (cmd_q)
    );

    // access setup, start and busy
    bubble_cfg_regs cfg_regs_i
    (
        .BOUTTICKS (BOUTTICKS),
        .reset     (reset),
        .cmd_stb   (cmd_stb),
        .cmd       (cmd_q),
        .done      (done),
        .acc_type  (acc_type),
        .rd_len    (rd_len),
        .start     (start),
        .busy      (busy)
    );

    bubble_read_sequencer #(
        .page_bits (page_bits)
    ) read_seq_i
    (
        .BOUTTICKS (BOUTTICKS),
        .reset     (reset),
        .start     (start),
        .acc_type  (acc_type),
        .rd_len    (rd_len),
        .rd        (rd),
        .done      (done)
    );

    // both channels, written by host, read by sequencer
    bubble_outbuffer #(
        .depth     (buf_depth)
    ) outbuffer_i
    (
        .BOUTTICKS (BOUTTICKS),
        .cmd_stb   (cmd_stb),
        .cmd       (cmd_q),
        .rd        (rd),
        .reset     (reset),
        .bout      (bout)
    );

endmodule

// ==== test/bubble_checker.sv ====
`timescale 1ns/1ps

module bubble_checker
(
    input logic BOUTTICKS,
    input logic reset,
    input logic req,
    input logic ack,
    input logic bout_valid,
    input logic busy,
    input logic start                           // internal kick from cfg regs
);

    // ack only comes up on a request seen at the previous edge
    property ack_rise_after_req;
        @(posedge BOUTTICKS) disable iff (reset)
        $rose(ack) |-> $past(req);
    endproperty

    // ack only drops once the host has let go of req
    property ack_fall_after_release;
        @(posedge BOUTTICKS) disable iff (reset)
        $fell(ack) |-> !$past(req);
    endproperty

    // a request seen with ack low gets ack one cycle later
    property ack_follows_req;
        @(posedge BOUTTICKS) disable iff (reset)
        (req && !ack) |=> ack;
    endproperty

    // reset state, one edge into reset so the flops are settled
    property quiet_in_reset;
        @(posedge BOUTTICKS)
        (reset && $past(reset)) |-> (!bout_valid && !ack && !busy);
    endproperty

    // busy never comes up on its own
    property busy_needs_start;
        @(posedge BOUTTICKS) disable iff (reset)
        $rose(busy) |-> start;
    endproperty

    ack_rise_a:  assert property (ack_rise_after_req)     else $error("ack rose without req");
    ack_fall_a:  assert property (ack_fall_after_release) else $error("ack fell while req high");
    ack_resp_a:  assert property (ack_follows_req)        else $error("req not answered by ack");
    reset_a:     assert property (quiet_in_reset)         else $error("outputs active in reset");
    busy_a:      assert property (busy_needs_start)       else $error("busy rose without start");

endmodule

// attach to every instance of the top level
bind bubble_interface_top bubble_checker checker_i
(
    .BOUTTICKS  (BOUTTICKS),
    .reset      (reset),
    .req        (req),
    .ack        (ack),
    .bout_valid (bout.valid),
    .busy       (busy),
    .start      (start)
);

// ==== test/bubble_tb.sv ====
`timescale 1ns/1ps

module bubble_tb;

    import bubble_pkg::*;

    localparam int timeout_cycles = 20000;      // all tests plus margin

    logic        BOUTTICKS;
    logic        reset;
    logic        req;
    host_cmd_t   cmd;
    logic        ack;
    bubble_out_t bout;
    logic        busy;

    int seed = 32'hef57;
    int err_data = 0;                           // wrong output bits
    int err_proto = 0;                          // handshake and reset state
    int err_count = 0;                          // burst length problems
    int stb_count = 0;                          // command strobes seen
    int outs_seen = 0;
    int exp_len = 0;
    int cycles = 0;

    logic       ref0 [8192];                    // reference copy of channel 0
    logic       ref1 [8192];
    logic [1:0] exp_q [$];                      // {dout0, dout1} per read cycle

    bubble_interface_top dut_i
    (
        .BOUTTICKS (BOUTTICKS),
        .reset     (reset),
        .req       (req),
        .cmd       (cmd),
        .ack       (ack),
        .bout      (bout),
        .busy      (busy)
    );

    initial BOUTTICKS = 1'b0;
    always #5 BOUTTICKS = ~BOUTTICKS;

    // run limit
    always @(posedge BOUTTICKS)
    begin
        cycles++;
        if (cycles >= timeout_cycles)
        begin
            $display("timeout reached after %0d cycles, read or handshake never finished", cycles);
            $display("Verification failed");
            $finish;
        end
    end

    // strobes counted mid-cycle, away from the edge
    always @(negedge BOUTTICKS)
    begin
        if (!reset && dut_i.cmd_stb)
        begin
            stb_count++;
        end
    end

    // output monitor, compares each valid cycle with the next expected pair
    always @(negedge BOUTTICKS)
    begin
        logic [1:0] want;
        if (!reset && bout.valid)
        begin
            assert (exp_q.size() != 0)
            else
            begin
                err_count++;
                $display("FAILED at %0t: valid output with no read pending", $time);
            end
            if (exp_q.size() != 0)
            begin
                want = exp_q.pop_front();
                outs_seen++;
                assert (bout.dout0 == want[1] && bout.dout1 == want[0])
                else
                begin
                    err_data++;
                    $display("FAILED at %0t: cycle %0d got %b%b, expected %b%b", $time,
                             outs_seen - 1, bout.dout0, bout.dout1, want[1], want[0]);
                end
            end
        end
    end

    // buffer address for read cycle n
    function automatic logic [12:0] exp_addr(input acc_type_e acc, input int n);
        logic [12:0] cyc;
        cyc = n[12:0];
        case (acc)
            acc_boot: exp_addr = cyc;
            acc_user: exp_addr = {3'b111, cyc[9:0]};    // page region from 7168
            default:  exp_addr = 13'h1fff;              // empty line
        endcase
    endfunction

    task automatic wait_cycles(input int n);
        repeat (n)
        begin
            @(posedge BOUTTICKS);
            #1;
        end
    endtask

    // one full four-phase handshake, entered and left 1 ns after an edge
    task automatic send_cmd(input host_op_e op, input logic [13:0] addr, input logic data,
                            input int hold);
        int stb_before;
        stb_before = stb_count;
        cmd.op   = op;
        cmd.addr = addr;
        cmd.data = data;
        req      = 1'b1;
        do
        begin
            @(posedge BOUTTICKS);
            #1;
        end
        while (!ack);
        wait_cycles(hold);                      // req held longer than needed
        req = 1'b0;
        do
        begin
            @(posedge BOUTTICKS);
            #1;
        end
        while (ack);
        assert (stb_count == stb_before + 1)
        else
        begin
            err_proto++;
            $display("handshake for opcode %0d gave %0d commands instead of one",
                     op, stb_count - stb_before);
        end
    endtask

    task automatic write_bit(input logic [12:0] a, input logic ch, input logic b);
        int rnd;
        int hold;
        rnd  = $random(seed);
        hold = rnd & 3;
        if (ch)
        begin
            ref1[a] = b;
        end
        else
        begin
            ref0[a] = b;
        end
        send_cmd(op_write_bit, {a, ch}, b, hold);   // bit 0 picks the channel
    endtask

    // random bits into both channels over [lo, hi)
    task automatic fill_random(input int lo, input int hi);
        int rnd;
        for (int i = lo; i < hi; i++)
        begin
            rnd = $random(seed);
            write_bit(13'(i), 1'b0, rnd[0]);
            write_bit(13'(i), 1'b1, rnd[1]);
        end
    endtask

    // setup, expectations and start, returns with the read running
    task automatic launch_read(input acc_type_e acc, input int len);
        logic [12:0] a;
        send_cmd(op_set_access, {11'd0, acc}, 1'b0, 0);
        send_cmd(op_set_length, 14'(len), 1'b0, 0);
        exp_q.delete();
        for (int n = 0; n < len; n++)
        begin
            a = exp_addr(acc, n);
            exp_q.push_back({~ref0[a], ~ref1[a]});  // detector lines inverted
        end
        exp_len   = len;
        outs_seen = 0;
        send_cmd(op_start, 14'd0, 1'b0, 0);
    endtask

    task automatic finish_read();
        do
        begin
            @(posedge BOUTTICKS);
            #1;
        end
        while (busy);
        wait_cycles(3);                         // last output still in the pipe
        assert (exp_q.size() == 0 && outs_seen == exp_len)
        else
        begin
            err_count++;
            $display("FAILED at %0t: read gave %0d outputs, expected %0d", $time,
                     outs_seen, exp_len);
        end
        exp_q.delete();
    endtask

    initial
    begin
        req   = 1'b0;
        cmd   = '0;
        reset = 1'b1;

        // reset state, held and just after
        for (int i = 0; i < 11; i++)
        begin
            @(posedge BOUTTICKS);
            #1;
            if (i == 7)
            begin
                reset = 1'b0;
            end
            assert (!ack && !busy && !bout.valid)
            else
            begin
                err_proto++;
                $display("FAILED at %0t: ack, busy or valid high around reset", $time);
            end
        end

        // zero length, nothing comes out
        launch_read(acc_boot, 0);
        finish_read();
        wait_cycles(10);

        // req hold times 0 to 7, back to back
        for (int h = 0; h < 8; h++)
        begin
            send_cmd(op_set_access, {11'd0, acc_user}, 1'b0, h);
        end

        // boot loop replay
        fill_random(0, 64);
        launch_read(acc_boot, 64);
        finish_read();

        // user page replay
        fill_random(7168, 7232);
        launch_read(acc_user, 64);
        finish_read();

        // empty propagation line
        write_bit(13'h1fff, 1'b0, 1'b1);
        write_bit(13'h1fff, 1'b1, 1'b0);
        launch_read(acc_idle, 16);
        finish_read();

        // restart and length change mid read both have no effect on the burst
        launch_read(acc_boot, 64);
        wait_cycles(10);
        send_cmd(op_start, 14'd0, 1'b0, 1);
        send_cmd(op_set_length, 14'd5, 1'b0, 0);
        finish_read();
        wait_cycles(100);                       // any second burst shows up here

        $display("errors: data %0d, handshake %0d, count %0d", err_data, err_proto, err_count);
        if (err_data + err_proto + err_count == 0)
        begin
            $display("Verification passed");
        end
        else
        begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

// ==== sources.f ====
rtl/bubble_pkg.sv
rtl/bubble_host_port.sv
rtl/bubble_cfg_regs.sv
rtl/bubble_read_sequencer.sv
rtl/bubble_outbuffer.sv
rtl/bubble_interface_top.sv
test/bubble_checker.sv
test/bubble_tb.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module bubble_tb -f sources.f -o Vbubble_tb

out=$(./obj_dir/Vbubble_tb) || true
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -qx "Verification passed"
